// ==== design/isa_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// isa package: accumulator core instruction set and FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

  // instruction word is {opcode, unused, operand}
  localparam int unsigned OPC_W  = 4;
  localparam int unsigned OPND_W = 8;

  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'd0,
    OP_LDI  = 4'd1,
    OP_LD   = 4'd2,
    OP_ST   = 4'd3,
    OP_ADD  = 4'd4,
    OP_XOR  = 4'd5,
    OP_JZ   = 4'd6,
    OP_JNZ  = 4'd7,
    OP_OUT  = 4'd8,
    OP_EXIT = 4'd9
  } opcode_e;

  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_FETCH  = 3'd1,
    ST_DECODE = 3'd2,
    ST_MEM    = 3'd3,
    ST_HALT   = 3'd4
  } core_state_e;

endpackage

// ==== design/bus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus package: shared SRAM bus widths and master indices
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bus_pkg;

  // word addressed, 256 words
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 16;

  // arbiter master indices
  localparam int unsigned MST_LOADER = 0;
  localparam int unsigned MST_CORE   = 1;

endpackage

// ==== design/sram_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sram bank: single-port synchronous word memory on the shared bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sram_bank (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  wdata_i,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o
);

  localparam int unsigned DEPTH = 2 ** bus_pkg::ADDR_W;

  logic [bus_pkg::DATA_W-1:0] mem_q [DEPTH];
  logic [bus_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_gen) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // read data held until the next read transfer
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  a_addr_known : assert property (
    @(posedge clk_gen) disable iff (!rst_n)
    req_i |-> !$isunknown(addr_i)
  );

endmodule

// ==== design/bus_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus arbiter: round-robin between loader and core, muxes the winner
// onto the SRAM port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bus_arbiter (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        ld_req_i,
  input  logic                        ld_we_i,
  input  logic [bus_pkg::ADDR_W-1:0]  ld_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  ld_wdata_i,
  input  logic                        core_req_i,
  input  logic                        core_we_i,
  input  logic [bus_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  core_wdata_i,
  output logic                        ld_gnt_o,
  output logic                        core_gnt_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [bus_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [bus_pkg::DATA_W-1:0]  mem_wdata_o
);

  localparam logic LAST_LOADER = 1'(bus_pkg::MST_LOADER);
  localparam logic LAST_CORE   = 1'(bus_pkg::MST_CORE);

  // index of the master granted in the last transfer
  logic last_gnt_q;

  // on a tie the master not served last wins
  assign ld_gnt_o   = ld_req_i && (!core_req_i || (last_gnt_q == LAST_CORE));
  assign core_gnt_o = core_req_i && (!ld_req_i || (last_gnt_q == LAST_LOADER));

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      last_gnt_q <= LAST_CORE;
    end else if (ld_gnt_o) begin
      last_gnt_q <= LAST_LOADER;
    end else if (core_gnt_o) begin
      last_gnt_q <= LAST_CORE;
    end
  end

  assign mem_req_o = ld_gnt_o || core_gnt_o;

  always_comb begin
    if (core_gnt_o) begin
      mem_we_o    = core_we_i;
      mem_addr_o  = core_addr_i;
      mem_wdata_o = core_wdata_i;
    end else begin
      mem_we_o    = ld_gnt_o && ld_we_i;
      mem_addr_o  = ld_addr_i;
      mem_wdata_o = ld_wdata_i;
    end
  end

  a_gnt_onehot : assert property (
    @(posedge clk_gen) disable iff (!rst_n)
    !(ld_gnt_o && core_gnt_o)
  );

  // a master kept waiting is served in the next cycle
  a_ld_wait_one : assert property (
    @(posedge clk_gen) disable iff (!rst_n)
    ld_req_i && !ld_gnt_o |=> ld_gnt_o
  );

  a_core_wait_one : assert property (
    @(posedge clk_gen) disable iff (!rst_n)
    core_req_i && !core_gnt_o |=> core_gnt_o
  );

endmodule

// ==== design/debug_loader.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug loader: buffers one strobed word and writes it over the bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module debug_loader (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        load_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  load_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  load_data_i,
  input  logic                        gnt_i,
  output logic                        load_busy_o,
  output logic                        req_o,
  output logic                        we_o,
  output logic [bus_pkg::ADDR_W-1:0]  addr_o,
  output logic [bus_pkg::DATA_W-1:0]  wdata_o
);

  logic                       pending_q;
  logic [bus_pkg::ADDR_W-1:0] addr_q;
  logic [bus_pkg::DATA_W-1:0] data_q;

  // buffer full until the write is granted
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      if (gnt_i) begin
        pending_q <= 1'b0;
      end
    end else if (load_valid_i) begin
      pending_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_gen) begin
    if (load_valid_i && !pending_q) begin
      addr_q <= load_addr_i;
      data_q <= load_data_i;
    end
  end

  assign load_busy_o = pending_q;
  assign req_o       = pending_q;
  // this master only ever writes
  assign we_o        = pending_q;
  assign addr_o      = addr_q;
  assign wdata_o     = data_q;

endmodule

// ==== design/acc_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accumulator core: multicycle fetch/decode/memory FSM with a GPIO
// register and an exit report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module acc_core #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic                        gnt_i,
  input  logic [bus_pkg::DATA_W-1:0]  rdata_i,
  output logic                        req_o,
  output logic                        we_o,
  output logic [bus_pkg::ADDR_W-1:0]  addr_o,
  output logic [bus_pkg::DATA_W-1:0]  wdata_o,
  output logic [GPIO_W-1:0]           gpio_o,
  output logic [bus_pkg::DATA_W-1:0]  exit_value_o,
  output logic                        exit_valid_o
);

  isa_pkg::core_state_e       state_q;
  isa_pkg::opcode_e           opc;
  logic                       rd_pend_q;
  logic [bus_pkg::ADDR_W-1:0] pc_q;
  logic [bus_pkg::DATA_W-1:0] instr_q;
  logic [bus_pkg::DATA_W-1:0] acc_q;
  logic [bus_pkg::ADDR_W-1:0] opnd;
  logic [GPIO_W-1:0]          gpio_q;
  logic [bus_pkg::DATA_W-1:0] exit_value_q;
  logic                       exit_valid_q;

  assign opc  = isa_pkg::opcode_e'(instr_q[bus_pkg::DATA_W-1 -: isa_pkg::OPC_W]);
  assign opnd = instr_q[isa_pkg::OPND_W-1:0];

  // request only in the address phase of a transfer
  assign req_o   = ((state_q == isa_pkg::ST_FETCH) || (state_q == isa_pkg::ST_MEM))
                   && !rd_pend_q;
  assign we_o    = (state_q == isa_pkg::ST_MEM) && (opc == isa_pkg::OP_ST);
  assign addr_o  = (state_q == isa_pkg::ST_MEM) ? opnd : pc_q;
  assign wdata_o = acc_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= isa_pkg::ST_IDLE;
      rd_pend_q    <= 1'b0;
      pc_q         <= '0;
      acc_q        <= '0;
      gpio_q       <= '0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else begin
      case (state_q)
        isa_pkg::ST_IDLE: begin
          if (start_i) begin
            pc_q         <= '0;
            acc_q        <= '0;
            exit_valid_q <= 1'b0;
            state_q      <= isa_pkg::ST_FETCH;
          end
        end
        isa_pkg::ST_FETCH: begin
          if (!rd_pend_q) begin
            rd_pend_q <= gnt_i;
          end else begin
            rd_pend_q <= 1'b0;
            pc_q      <= pc_q + 1'b1;
            state_q   <= isa_pkg::ST_DECODE;
          end
        end
        isa_pkg::ST_DECODE: begin
          state_q <= isa_pkg::ST_FETCH;
          case (opc)
            isa_pkg::OP_LDI: acc_q <= bus_pkg::DATA_W'(opnd);
            isa_pkg::OP_LD, isa_pkg::OP_ST,
            isa_pkg::OP_ADD, isa_pkg::OP_XOR: state_q <= isa_pkg::ST_MEM;
            isa_pkg::OP_JZ: begin
              if (acc_q == '0) begin
                pc_q <= opnd;
              end
            end
            isa_pkg::OP_JNZ: begin
              if (acc_q != '0) begin
                pc_q <= opnd;
              end
            end
            isa_pkg::OP_OUT: gpio_q <= acc_q[GPIO_W-1:0];
            isa_pkg::OP_EXIT: begin
              exit_value_q <= acc_q;
              exit_valid_q <= 1'b1;
              state_q      <= isa_pkg::ST_HALT;
            end
            default: ;
          endcase
        end
        isa_pkg::ST_MEM: begin
          if (!rd_pend_q) begin
            rd_pend_q <= gnt_i;
          end else begin
            // operand word is on rdata this cycle
            rd_pend_q <= 1'b0;
            state_q   <= isa_pkg::ST_FETCH;
            case (opc)
              isa_pkg::OP_LD:  acc_q <= rdata_i;
              isa_pkg::OP_ADD: acc_q <= acc_q + rdata_i;
              isa_pkg::OP_XOR: acc_q <= acc_q ^ rdata_i;
              default: ;
            endcase
          end
        end
        // exit report stays up in idle until the next start
        isa_pkg::ST_HALT: state_q <= isa_pkg::ST_IDLE;
        default: state_q <= isa_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_gen) begin
    if ((state_q == isa_pkg::ST_FETCH) && rd_pend_q) begin
      instr_q <= rdata_i;
    end
  end

  assign gpio_o       = gpio_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  // request and its fields held until granted
  a_req_held : assert property (
    @(posedge clk_gen) disable iff (!rst_n)
    req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(we_o) && $stable(wdata_o)
  );

endmodule

// ==== design/mini_mcu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu: loader and core sharing one SRAM through the arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mini_mcu #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic                        load_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  load_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  load_data_i,
  output logic                        load_busy_o,
  output logic [GPIO_W-1:0]           gpio_o,
  output logic [bus_pkg::DATA_W-1:0]  exit_value_o,
  output logic                        exit_valid_o
);

  logic                       ld_req, ld_we, ld_gnt;
  logic [bus_pkg::ADDR_W-1:0] ld_addr;
  logic [bus_pkg::DATA_W-1:0] ld_wdata;
  logic                       core_req, core_we, core_gnt;
  logic [bus_pkg::ADDR_W-1:0] core_addr;
  logic [bus_pkg::DATA_W-1:0] core_wdata;
  logic                       mem_req, mem_we;
  logic [bus_pkg::ADDR_W-1:0] mem_addr;
  logic [bus_pkg::DATA_W-1:0] mem_wdata, mem_rdata;

  debug_loader debug_loader_i (
    .clk_gen, .rst_n, .load_valid_i, .load_addr_i, .load_data_i,
    .gnt_i(ld_gnt), .load_busy_o, .req_o(ld_req), .we_o(ld_we),
    .addr_o(ld_addr), .wdata_o(ld_wdata)
  );

  acc_core #(.GPIO_W(GPIO_W)) acc_core_i (
    .clk_gen, .rst_n, .start_i, .gnt_i(core_gnt), .rdata_i(mem_rdata),
    .req_o(core_req), .we_o(core_we), .addr_o(core_addr), .wdata_o(core_wdata),
    .gpio_o, .exit_value_o, .exit_valid_o
  );

  bus_arbiter bus_arbiter_i (
    .clk_gen, .rst_n,
    .ld_req_i(ld_req), .ld_we_i(ld_we), .ld_addr_i(ld_addr), .ld_wdata_i(ld_wdata),
    .core_req_i(core_req), .core_we_i(core_we), .core_addr_i(core_addr),
    .core_wdata_i(core_wdata), .ld_gnt_o(ld_gnt), .core_gnt_o(core_gnt),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata)
  );

  sram_bank sram_bank_i (
    .clk_gen, .rst_n, .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

endmodule

// ==== design/board_wrapper.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board wrapper: mini mcu with reset LED, blinking clock LED and the
// exit report brought out to the pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module board_wrapper #(
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27,
  parameter int unsigned GPIO_W               = 8
) (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic                        load_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  load_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  load_data_i,
  output logic                        load_busy_o,
  output logic [GPIO_W-1:0]           gpio_o,
  output logic [bus_pkg::DATA_W-1:0]  exit_value_o,
  output logic                        exit_valid_o,
  output logic                        rst_led_o,
  output logic                        clk_led_o
);

  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  // lit while the system is out of reset
  assign rst_led_o = rst_n;

  // free-running blink counter, msb drives the LED
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  mini_mcu #(
    .GPIO_W(GPIO_W)
  ) mini_mcu_i (
    .clk_gen,
    .rst_n,
    .start_i,
    .load_valid_i,
    .load_addr_i,
    .load_data_i,
    .load_busy_o,
    .gpio_o,
    .exit_value_o,
    .exit_valid_o
  );

endmodule

// ==== tb/tb_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench model: LFSR stimulus, random program generator and the ISA
// reference model that predicts gpio changes and exit values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0]                lfsr_q = 16'd26930;
logic [bus_pkg::DATA_W-1:0] ref_mem [2**bus_pkg::ADDR_W];
logic [bus_pkg::DATA_W-1:0] prog_q [$];
logic [GPIO_W-1:0]          ref_gpio = '0;
logic [GPIO_W-1:0]          exp_gpio [$];

// galois LFSR, one step per bit taken
function automatic int rand_bits(int n);
  int r = 0;
  for (int i = 0; i < n; i++) begin
    r = (r << 1) | int'(lfsr_q[0]);
    lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
  end
  return r;
endfunction

// bits 11:8 get noise, the core ignores them
function automatic logic [15:0] encode_instr(logic [3:0] opc, int opnd);
  return {opc, 4'(rand_bits(4)), 8'(opnd)};
endfunction

function automatic void gen_program();
  int len, code, opnd;
  len = 12 + rand_bits(5) % 29;
  prog_q.delete();
  for (int i = 0; i < len - 1; i++) begin
    code = rand_bits(4);
    // exit only in the last slot
    code = (code == int'(isa_pkg::OP_EXIT)) ? int'(isa_pkg::OP_OUT) : code;
    opnd = rand_bits(8);
    case (4'(code))
      isa_pkg::OP_LD, isa_pkg::OP_ST, isa_pkg::OP_ADD, isa_pkg::OP_XOR:
        opnd = DATA_BASE + opnd % DATA_WORDS;
      // forward only, clipped to the exit
      isa_pkg::OP_JZ, isa_pkg::OP_JNZ:
        opnd = (i + 1 + opnd % 8 < len) ? i + 1 + opnd % 8 : len - 1;
      default: ;
    endcase
    prog_q.push_back(encode_instr(4'(code), opnd));
  end
  prog_q.push_back(encode_instr(isa_pkg::OP_EXIT, 0));
endfunction

// runs from pc 0 on ref_mem, queues each gpio change an OUT causes
function automatic logic [15:0] run_model();
  logic [7:0]  pc = '0;
  logic [15:0] acc = '0;
  logic [15:0] ir;
  for (int step = 0; step < 1024; step++) begin
    ir = ref_mem[pc];
    pc = pc + 1'b1;
    case (ir[15:12])
      isa_pkg::OP_LDI: acc = 16'(ir[7:0]);
      isa_pkg::OP_LD:  acc = ref_mem[ir[7:0]];
      isa_pkg::OP_ST:  ref_mem[ir[7:0]] = acc;
      isa_pkg::OP_ADD: acc = acc + ref_mem[ir[7:0]];
      isa_pkg::OP_XOR: acc = acc ^ ref_mem[ir[7:0]];
      isa_pkg::OP_JZ:  pc = (acc == '0) ? ir[7:0] : pc;
      isa_pkg::OP_JNZ: pc = (acc != '0) ? ir[7:0] : pc;
      isa_pkg::OP_OUT: begin
        if (acc[GPIO_W-1:0] != ref_gpio) begin
          exp_gpio.push_back(acc[GPIO_W-1:0]);
        end
        ref_gpio = acc[GPIO_W-1:0];
      end
      isa_pkg::OP_EXIT: return acc;
      default: ;
    endcase
  end
  return acc;
endfunction

`endif

// ==== tb/tb_board_wrapper.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the board wrapper: random programs loaded through the
// debug loader and run on the core, checked against an ISA model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_board_wrapper;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned GPIO_W     = 8;
  localparam int unsigned DATA_BASE  = 200;
  localparam int unsigned DATA_WORDS = 16;
  localparam int unsigned FLAG_ADDR  = 250;
  localparam int unsigned NUM_PROGS  = 8;
  // per round 89 words loaded at about 4 cycles, at most 73 instructions at 12
  localparam int unsigned TIMEOUT_CYC = 2 * (NUM_PROGS * (89 * 4 + 73 * 12) + 500);

  logic                       clk_gen = 1'b0;
  logic                       rst_n, start_i, load_valid_i, load_busy_o;
  logic [bus_pkg::ADDR_W-1:0] load_addr_i;
  logic [bus_pkg::DATA_W-1:0] load_data_i, exit_value_o, exp_exit, flag;
  logic                       exit_valid_o, rst_led_o, clk_led_o;
  logic [GPIO_W-1:0]          gpio_o, gpio_last, gpio_exp;
  int                         cycle_cnt = 0, led_cnt = 0;
  int                         exit_errs = 0, gpio_errs = 0, other_errs = 0;
  string                      test_name = "reset";

  `include "tb_model.svh"

  board_wrapper #(.CLK_LED_COUNT_LENGTH(4), .GPIO_W(GPIO_W)) dut_i (.*);

  always #50 clk_gen = ~clk_gen;

  always @(posedge clk_gen) begin
    cycle_cnt++;
    if (rst_n) begin
      led_cnt++;
    end
    if (cycle_cnt > TIMEOUT_CYC) begin
      $display("timeout after %0d cycles in %s, the DUT stopped responding", cycle_cnt,
               test_name);
      $display("sim failed");
      $finish;
    end
  end

  // mid-cycle sampling, clear of the edge
  always @(negedge clk_gen) begin
    if (rst_n && clk_led_o !== led_cnt[3]) begin
      $display("FAIL %s clk_led expected %b actual %b", test_name, led_cnt[3], clk_led_o);
      other_errs++;
    end
    if (rst_n && gpio_o !== gpio_last) begin
      // no pending OUT means gpio should have held
      gpio_exp = (exp_gpio.size() > 0) ? exp_gpio.pop_front() : gpio_last;
      if (gpio_o !== gpio_exp) begin
        $display("FAIL %s gpio expected %h actual %h", test_name, gpio_exp, gpio_o);
        gpio_errs++;
      end
      gpio_last = gpio_o;
    end
  end

  task automatic check_value(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      other_errs++;
    end
  endtask

  task automatic load_word(input int addr, input logic [bus_pkg::DATA_W-1:0] data);
    @(posedge clk_gen);
    #1;
    load_valid_i  = 1'b1;
    load_addr_i   = bus_pkg::ADDR_W'(addr);
    load_data_i   = data;
    ref_mem[addr] = data;
    @(posedge clk_gen);
    #1;
    load_valid_i = 1'b0;
    while (load_busy_o) begin
      @(posedge clk_gen);
      #1;
    end
  endtask

  task automatic run_program(input logic poke_flag);
    foreach (prog_q[i]) begin
      load_word(i, prog_q[i]);
    end
    exp_exit = run_model();
    @(posedge clk_gen);
    #1;
    start_i = 1'b1;
    @(posedge clk_gen);
    #1;
    start_i = 1'b0;
    // flag written by the loader while the core polls it
    if (poke_flag) begin
      repeat (8 + rand_bits(4)) @(posedge clk_gen);
      load_word(FLAG_ADDR, flag);
    end
    while (!exit_valid_o) begin
      @(posedge clk_gen);
      #1;
    end
    if (exit_value_o !== exp_exit) begin
      $display("FAIL %s exit expected %h actual %h", test_name, exp_exit, exit_value_o);
      exit_errs++;
    end
    if (exp_gpio.size() != 0) begin
      $display("%s: %0d gpio changes never seen", test_name, exp_gpio.size());
      gpio_errs++;
      exp_gpio.delete();
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    start_i      = 1'b0;
    load_valid_i = 1'b0;
    load_addr_i  = '0;
    load_data_i  = '0;
    gpio_last    = '0;
    repeat (3) @(posedge clk_gen);
    #1;
    // reset LED dark while reset is held
    check_value("rst_led", 16'd0, 16'(rst_led_o));
    rst_n = 1'b1;
    @(posedge clk_gen);
    #1;
    check_value("exit_valid", 16'd0, 16'(exit_valid_o));
    check_value("load_busy", 16'd0, 16'(load_busy_o));
    check_value("gpio", 16'd0, 16'(gpio_o));
    check_value("rst_led", 16'd1, 16'(rst_led_o));
    for (int p = 0; p < NUM_PROGS; p++) begin
      test_name = "random";
      for (int a = 0; a < DATA_WORDS; a++) begin
        load_word(DATA_BASE + a, 16'(rand_bits(16)));
      end
      gen_program();
      run_program(1'b0);
      // stored words read back through LD and OUT
      test_name = "readback";
      prog_q.delete();
      for (int a = 0; a < DATA_WORDS; a++) begin
        prog_q.push_back(encode_instr(isa_pkg::OP_LD, DATA_BASE + a));
        prog_q.push_back(encode_instr(isa_pkg::OP_OUT, 0));
      end
      prog_q.push_back(encode_instr(isa_pkg::OP_EXIT, 0));
      run_program(1'b0);
    end
    test_name = "contention";
    load_word(FLAG_ADDR, '0);
    flag = 16'(rand_bits(16)) | 16'd1;
    ref_mem[FLAG_ADDR] = flag;
    prog_q = {encode_instr(isa_pkg::OP_LD, FLAG_ADDR), encode_instr(isa_pkg::OP_JZ, 0),
              encode_instr(isa_pkg::OP_OUT, 0), encode_instr(isa_pkg::OP_EXIT, 0)};
    run_program(1'b1);
    $display("errors: %0d (exit %0d, gpio %0d, other %0d)",
             exit_errs + gpio_errs + other_errs, exit_errs, gpio_errs, other_errs);
    if (exit_errs + gpio_errs + other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+tb
design/isa_pkg.sv
design/bus_pkg.sv
design/sram_bank.sv
design/bus_arbiter.sv
design/debug_loader.sv
design/acc_core.sv
design/mini_mcu.sv
design/board_wrapper.sv
tb/tb_board_wrapper.sv

// ==== Bender.yml ====
package:
  name: board_wrapper

sources:
  - design/isa_pkg.sv
  - design/bus_pkg.sv
  - design/sram_bank.sv
  - design/bus_arbiter.sv
  - design/debug_loader.sv
  - design/acc_core.sv
  - design/mini_mcu.sv
  - design/board_wrapper.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_board_wrapper.sv
